// ==== hdl/rv_fe_pkg.sv ====
`default_nettype none

package rv_fe_pkg;

    typedef logic [31:0] arch_width_t;

    // first fetch address, zero is reserved to mark an empty slot
    localparam arch_width_t RESET_VEC = 32'h0000_0100;

    typedef enum logic [1:0] {
        PC_SEL_PC   = 2'd0,
        PC_SEL_INC4 = 2'd1,
        PC_SEL_ALU  = 2'd2
    } pc_sel_t;

    typedef enum logic {
        B_NT = 1'b0,
        B_T  = 1'b1
    } branch_t;

    typedef struct packed {
        pc_sel_t pc_sel;
        logic    pc_we;
        logic    bubble_dec;
    } fe_ctrl_t;

    localparam fe_ctrl_t FE_CTRL_INIT = '{pc_sel: PC_SEL_PC, pc_we: 1'b0, bubble_dec: 1'b0};

    typedef struct packed {
        logic to_dec;
        logic to_exe;
    } hazard_t;

    typedef struct packed {
        logic        valid;
        arch_width_t addr;
    } imem_req_t;

    typedef struct packed {
        logic        valid;
        arch_width_t data;
    } imem_rsp_t;

    typedef struct packed {
        arch_width_t pc;
        arch_width_t inst;
    } dec_slot_t;

    typedef struct packed {
        arch_width_t pc;
        arch_width_t inst;
        logic        is_branch;
        logic        is_jalr;
    } exe_slot_t;

    localparam logic [6:0] OPC_BRANCH = 7'h63;
    localparam logic [6:0] OPC_JALR   = 7'h67;

endpackage

`default_nettype wire

// ==== hdl/rv_fe_pc_gen.sv ====
`default_nettype none

module rv_fe_pc_gen
    import rv_fe_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire pc_sel_t     pc_sel,
    input  wire logic        pc_we,
    input  wire arch_width_t alu_target,
    output arch_width_t      pc
);

    arch_width_t pc_nx;

    // next fetch address
    always_comb begin
        case (pc_sel)
            PC_SEL_INC4: pc_nx = pc + 32'd4;
            PC_SEL_ALU:  pc_nx = alu_target;
            default:     pc_nx = pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VEC;
        end else if (pc_we) begin
            pc <= pc_nx;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_fe_flow_decode.sv ====
`default_nettype none

module rv_fe_flow_decode
    import rv_fe_pkg::*;
(
    input  wire dec_slot_t dec_slot,
    input  wire logic      dec_valid,
    output logic           branch_in_dec,
    output logic           jalr_in_dec,
    output fe_ctrl_t       decoded_fe_ctrl
);

    logic [6:0] opcode;

    assign opcode = dec_slot.inst[6:0];

    // jal is not treated as a flow change here
    assign branch_in_dec = dec_valid && (opcode == OPC_BRANCH);
    assign jalr_in_dec   = dec_valid && (opcode == OPC_JALR);

    // default front end control, controller overrides it on stalls
    always_comb begin
        decoded_fe_ctrl            = FE_CTRL_INIT;
        decoded_fe_ctrl.pc_sel     = PC_SEL_INC4;
        decoded_fe_ctrl.pc_we      = 1'b1;
        decoded_fe_ctrl.bubble_dec = 1'b0;
    end

endmodule

`default_nettype wire

// ==== hdl/rv_fe_stage_reg.sv ====
`default_nettype none

module rv_fe_stage_reg
    import rv_fe_pkg::*;
#(
    parameter type slot_t = dec_slot_t
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  load,
    input  wire logic  hold,
    input  wire logic  bubble,
    input  wire slot_t slot_in,
    output logic       valid_out,
    output slot_t      slot_out
);

    // cleared slot reads as pc 0, the empty marker
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
            slot_out  <= '0;
        end else if (!hold) begin
            if (bubble || !load) begin
                valid_out <= 1'b0;
                slot_out  <= '0;
            end else begin
                valid_out <= 1'b1;
                slot_out  <= slot_in;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_fe_ctrl.sv ====
`default_nettype none

module rv_fe_ctrl
    import rv_fe_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        req_ready,
    input  wire logic        rsp_valid,
    input  wire arch_width_t pc_dec,
    input  wire arch_width_t pc_exe,
    input  wire logic        branch_in_dec,
    input  wire logic        jalr_in_dec,
    input  wire logic        branch_in_exe,
    input  wire logic        jalr_in_exe,
    input  wire branch_t     branch_resolution,
    input  wire logic        dc_stalled,
    input  wire hazard_t     hazard,
    input  wire fe_ctrl_t    decoded_fe_ctrl,
    output logic             req_valid,
    output logic             rsp_ready,
    output fe_ctrl_t         fe_ctrl
);

    typedef enum logic [2:0] {
        RST,
        STEADY,
        STALL_FLOW,
        STALL_FE_IC,
        STALL_BE
    } stall_state_t;

    typedef struct packed {
        logic flow;
        logic icache;
        logic be;
    } stall_sources_t;

    stall_state_t   state;
    stall_state_t   state_nx;
    stall_sources_t stall_act;
    stall_sources_t stall_res;
    logic           branch_taken;
    logic           flow_update;
    logic           flow_fire;
    logic           stall_res_flow_d;
    logic           save_stall_entry;
    logic           clear_stall_entry;
    arch_width_t    stalled_pc;
    fe_ctrl_t       decoded_fe_ctrl_d;

    assign branch_taken = branch_in_exe && (branch_resolution == B_T);
    assign flow_update  = branch_taken || jalr_in_exe;

    assign stall_act.flow   = branch_in_dec || jalr_in_dec;
    assign stall_act.icache = !req_ready;
    assign stall_act.be     = dc_stalled || hazard.to_exe;

    // stalled instruction has reached execute
    assign stall_res.flow   = (stalled_pc == pc_exe) && (pc_exe != '0) && !hazard.to_exe;
    assign stall_res.icache = rsp_valid;
    assign stall_res.be     = !stall_act.be;

    // act once per resolution, even if execute is held afterwards
    assign flow_fire = stall_res.flow && stall_res.be && !stall_res_flow_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            stall_res_flow_d <= 1'b0;
        end else begin
            stall_res_flow_d <= flow_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RST;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx          = state;
        save_stall_entry  = 1'b0;
        clear_stall_entry = 1'b0;

        case (state)
            RST: begin
                // boot request at the reset vector
                if (!stall_act.icache) begin
                    state_nx = STALL_FE_IC;
                end
            end

            STEADY: begin
                clear_stall_entry = 1'b1;
                if (stall_act.be) begin
                    state_nx = STALL_BE;
                end else if (stall_act.flow) begin
                    save_stall_entry = 1'b1;
                    state_nx         = STALL_FLOW;
                end else if (!stall_act.icache) begin
                    // wait for the word of the accepted request
                    state_nx = STALL_FE_IC;
                end
            end

            STALL_FLOW: begin
                if (flow_fire) begin
                    state_nx = STEADY;
                end
            end

            STALL_FE_IC: begin
                if (stall_res.icache && stall_res.be) begin
                    state_nx = STEADY;
                end
            end

            STALL_BE: begin
                if (stall_res.be) begin
                    state_nx = STEADY;
                end
            end

            default: state_nx = RST;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stalled_pc <= '0;
        end else if (save_stall_entry) begin
            stalled_pc <= pc_dec;
        end else if (clear_stall_entry) begin
            stalled_pc <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decoded_fe_ctrl_d <= FE_CTRL_INIT;
        end else begin
            decoded_fe_ctrl_d <= decoded_fe_ctrl;
        end
    end

    always_comb begin
        fe_ctrl            = FE_CTRL_INIT;
        fe_ctrl.pc_sel     = decoded_fe_ctrl_d.pc_sel;
        req_valid          = 1'b0;
        rsp_ready          = 1'b0;

        case (state)
            RST: begin
                // boot request goes out once reset is released
                fe_ctrl.pc_sel     = PC_SEL_PC;
                fe_ctrl.bubble_dec = 1'b1;
                req_valid          = !rst;
            end

            STEADY: begin
                // decode moves on to execute while the next word is requested
                fe_ctrl.pc_sel = PC_SEL_PC;
                req_valid      = !stall_act.be && !stall_act.flow;
            end

            STALL_FLOW: begin
                fe_ctrl.bubble_dec = 1'b1;
                if (flow_fire) begin
                    // pc already points past the branch on the not taken path
                    fe_ctrl.pc_sel = flow_update ? PC_SEL_ALU : PC_SEL_PC;
                    fe_ctrl.pc_we  = 1'b1;
                end
            end

            STALL_FE_IC: begin
                fe_ctrl.pc_sel     = PC_SEL_PC;
                fe_ctrl.bubble_dec = 1'b1;
                rsp_ready          = stall_res.be;
                if (stall_res.icache && stall_res.be) begin
                    // advance to the following address as the word returns
                    fe_ctrl.pc_sel     = decoded_fe_ctrl.pc_sel;
                    fe_ctrl.pc_we      = decoded_fe_ctrl.pc_we;
                    fe_ctrl.bubble_dec = 1'b0;
                end
            end

            STALL_BE: begin
                // no requests while the backend is busy
                fe_ctrl.pc_we = 1'b0;
            end

            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/rv_fe_top.sv ====
`default_nettype none

module rv_fe_top
    import rv_fe_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        req_ready,
    input  wire imem_rsp_t   imem_rsp,
    input  wire branch_t     branch_resolution,
    input  wire arch_width_t alu_target,
    input  wire logic        dc_stalled,
    input  wire hazard_t     hazard,
    output imem_req_t        imem_req,
    output logic             rsp_ready,
    output logic             exe_valid,
    output exe_slot_t        exe_slot
);

    arch_width_t pc;
    fe_ctrl_t    fe_ctrl;
    fe_ctrl_t    decoded_fe_ctrl;
    dec_slot_t   dec_slot;
    logic        dec_valid;
    logic        branch_in_dec;
    logic        jalr_in_dec;
    logic        req_valid;

    assign imem_req = '{valid: req_valid, addr: pc};

    rv_fe_pc_gen u_pc_gen (
        .clk        (clk),
        .rst        (rst),
        .pc_sel     (fe_ctrl.pc_sel),
        .pc_we      (fe_ctrl.pc_we),
        .alu_target (alu_target),
        .pc         (pc)
    );

    // pc still holds the address of the returning word
    rv_fe_stage_reg #(.slot_t(dec_slot_t)) u_dec_reg (
        .clk       (clk),
        .rst       (rst),
        .load      (imem_rsp.valid && rsp_ready),
        .hold      (dc_stalled || hazard.to_exe),
        .bubble    (1'b0),
        .slot_in   ('{pc: pc, inst: imem_rsp.data}),
        .valid_out (dec_valid),
        .slot_out  (dec_slot)
    );

    rv_fe_flow_decode u_flow_decode (
        .dec_slot        (dec_slot),
        .dec_valid       (dec_valid),
        .branch_in_dec   (branch_in_dec),
        .jalr_in_dec     (jalr_in_dec),
        .decoded_fe_ctrl (decoded_fe_ctrl)
    );

    rv_fe_stage_reg #(.slot_t(exe_slot_t)) u_exe_reg (
        .clk       (clk),
        .rst       (rst),
        .load      (dec_valid),
        .hold      (dc_stalled || hazard.to_exe),
        .bubble    (fe_ctrl.bubble_dec),
        .slot_in   ('{pc: dec_slot.pc, inst: dec_slot.inst,
                      is_branch: branch_in_dec, is_jalr: jalr_in_dec}),
        .valid_out (exe_valid),
        .slot_out  (exe_slot)
    );

    rv_fe_ctrl u_ctrl (
        .clk               (clk),
        .rst               (rst),
        .req_ready         (req_ready),
        .rsp_valid         (imem_rsp.valid),
        .pc_dec            (dec_slot.pc),
        .pc_exe            (exe_slot.pc),
        .branch_in_dec     (branch_in_dec),
        .jalr_in_dec       (jalr_in_dec),
        .branch_in_exe     (exe_slot.is_branch),
        .jalr_in_exe       (exe_slot.is_jalr),
        .branch_resolution (branch_resolution),
        .dc_stalled        (dc_stalled),
        .hazard            (hazard),
        .decoded_fe_ctrl   (decoded_fe_ctrl),
        .req_valid         (req_valid),
        .rsp_ready         (rsp_ready),
        .fe_ctrl           (fe_ctrl)
    );

endmodule

`default_nettype wire

// ==== testbench/rv_fe_tb.sv ====
`default_nettype none

module rv_fe_tb
    import rv_fe_pkg::*;
();

    localparam int          CLK_PERIOD   = 40;
    localparam int          DRIVE_DELAY  = 2;
    localparam int          RESET_CYCLES = 16;
    localparam int          ROM_AW       = 6;
    localparam int          ROM_WORDS    = 1 << ROM_AW;
    localparam int          N_MAIN       = 200;
    localparam int          N_STRETCH    = 200;
    localparam int          CPI_BOUND    = 48;
    localparam int          WATCHDOG     =
        (RESET_CYCLES + 20 + (N_MAIN + N_STRETCH) * CPI_BOUND) * CLK_PERIOD;
    localparam logic [31:0] LFSR_POLY    = 32'hA300_0000;

    logic        clk;
    logic        rst;
    logic        req_ready;
    imem_rsp_t   imem_rsp;
    branch_t     branch_resolution;
    arch_width_t alu_target;
    logic        dc_stalled;
    hazard_t     hazard;
    imem_req_t   imem_req;
    logic        rsp_ready;
    logic        exe_valid;
    exe_slot_t   exe_slot;

    logic [31:0] lfsr;
    logic [31:0] rom [ROM_WORDS];
    logic        stretch_mode;
    int          ready_cnt;
    logic        mem_busy;
    int          mem_wait;
    arch_width_t mem_addr;
    // next fetch address in program order and whether it is known yet
    arch_width_t fetch_next;
    logic        fetch_known;
    arch_width_t exp_pc;
    logic        need_new;
    logic        cur_taken;
    arch_width_t cur_target;
    int          stall_left;
    logic        stall_kind;
    logic        held;
    logic        held_valid;
    exe_slot_t   held_slot;
    logic        first_req_seen;
    int          retired;
    int          errors;
    int          tests_failed;

    rv_fe_top dut_i (
        .clk               (clk),
        .rst               (rst),
        .req_ready         (req_ready),
        .imem_rsp          (imem_rsp),
        .branch_resolution (branch_resolution),
        .alu_target        (alu_target),
        .dc_stalled        (dc_stalled),
        .hazard            (hazard),
        .imem_req          (imem_req),
        .rsp_ready         (rsp_ready),
        .exe_valid         (exe_valid),
        .exe_slot          (exe_slot)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        b;
        val = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (b ? LFSR_POLY : 32'h0);
            val  = {val[30:0], b};
        end
        return val;
    endfunction

    function automatic logic [31:0] rom_word(input arch_width_t addr);
        arch_width_t offs;
        offs = addr - RESET_VEC;
        if (addr < RESET_VEC || addr[1:0] != 2'b00 || (offs >> 2) >= ROM_WORDS) begin
            return 32'h0;
        end
        return rom[offs[ROM_AW+1:2]];
    endfunction

    task automatic report_value(input string name, input logic [65:0] got,
                                input logic [65:0] exp);
        $display("[FAIL] %s: got %0h, expected %0h at time %0t", name, got, exp, $time);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s at time %0t", msg, $time);
        errors++;
    endtask

    // alu, branch and jalr words with a jalr back into the rom in the last slot
    task automatic fill_rom;
        logic [2:0]  kind;
        logic [6:0]  opc;
        logic [31:0] upper;
        for (int i = 0; i < ROM_WORDS; i++) begin
            kind = rand_bits(3);
            if (i == ROM_WORDS - 1 || kind == 3'd7) begin
                opc = OPC_JALR;
            end else if (kind >= 3'd5) begin
                opc = OPC_BRANCH;
            end else begin
                opc = kind[0] ? 7'h13 : 7'h33;
            end
            upper  = rand_bits(25);
            rom[i] = {upper[24:0], opc};
        end
    endtask

    task automatic drive_memory;
        if (ready_cnt == 0) begin
            if (stretch_mode) begin
                req_ready = rand_bits(1) != 0;
                ready_cnt = rand_bits(4);
            end else begin
                req_ready = rand_bits(2) != 0;
                ready_cnt = rand_bits(1);
            end
        end else begin
            ready_cnt--;
        end
        if (!mem_busy) begin
            imem_rsp = '0;
        end else if (mem_wait > 0) begin
            mem_wait--;
            if (mem_wait == 0) begin
                imem_rsp.valid = 1'b1;
                imem_rsp.data  = rom_word(mem_addr);
            end
        end
    endtask

    // outcome and stall are fixed once per instruction in execute
    task automatic drive_backend;
        arch_width_t idx;
        if (exe_valid && need_new) begin
            need_new   = 1'b0;
            cur_taken  = rand_bits(1) != 0;
            idx        = rand_bits(ROM_AW);
            cur_target = RESET_VEC + (idx << 2);
            stall_left = (rand_bits(2) == 0) ? 1 + rand_bits(2) : 0;
            stall_kind = rand_bits(1) != 0;
        end
        dc_stalled    = 1'b0;
        hazard.to_exe = 1'b0;
        if (exe_valid && stall_left > 0) begin
            stall_left--;
            if (stall_kind) begin
                hazard.to_exe = 1'b1;
            end else begin
                dc_stalled = 1'b1;
            end
        end
        branch_resolution = (exe_valid && cur_taken) ? B_T : B_NT;
        alu_target        = exe_valid ? cur_target : '0;
    endtask

    task automatic check_hold;
        if (held) begin
            if (exe_valid !== held_valid) begin
                report_value("exe_valid", exe_valid, held_valid);
            end
            if (exe_slot !== held_slot) begin
                report_value("exe_slot", exe_slot, held_slot);
            end
        end
    endtask

    task automatic retire_inst;
        logic [31:0] word;
        logic        is_br;
        logic        is_jr;
        word  = rom_word(exp_pc);
        is_br = word[6:0] == OPC_BRANCH;
        is_jr = word[6:0] == OPC_JALR;
        if (exe_slot.pc !== exp_pc) begin
            report_value("exe_slot.pc", exe_slot.pc, exp_pc);
        end
        if (exe_slot.inst !== word) begin
            report_value("exe_slot.inst", exe_slot.inst, word);
        end
        if (exe_slot.is_branch !== is_br || exe_slot.is_jalr !== is_jr) begin
            report_value("exe_slot.is_branch/is_jalr",
                         {exe_slot.is_branch, exe_slot.is_jalr}, {is_br, is_jr});
        end
        exp_pc = ((is_br && cur_taken) || is_jr) ? cur_target : exp_pc + 32'd4;
        if (is_br || is_jr) begin
            fetch_next  = exp_pc;
            fetch_known = 1'b1;
        end
        retired++;
        need_new = 1'b1;
    endtask

    // events of the coming rising edge
    task automatic sample_edge;
        logic        be;
        logic [31:0] word;
        be         = dc_stalled || hazard.to_exe;
        held       = be;
        held_valid = exe_valid;
        held_slot  = exe_slot;
        if (be && imem_req.valid) begin
            report_error("request issued during a backend stall");
        end
        if (be && rsp_ready) begin
            report_error("response accepted during a backend stall");
        end
        if (imem_req.valid && req_ready) begin
            first_req_seen = 1'b1;
            if (mem_busy) begin
                report_error("second request while one is outstanding");
            end
            if (!fetch_known) begin
                report_error($sformatf("request to %h before the flow change resolved",
                                       imem_req.addr));
            end else if (imem_req.addr !== fetch_next) begin
                report_value("imem_req.addr", imem_req.addr, fetch_next);
            end
            fetch_known = 1'b0;
            mem_busy    = 1'b1;
            mem_addr    = imem_req.addr;
            mem_wait    = 1 + rand_bits(2);
        end
        if (imem_rsp.valid && rsp_ready) begin
            word     = rom_word(mem_addr);
            mem_busy = 1'b0;
            if (word[6:0] != OPC_BRANCH && word[6:0] != OPC_JALR) begin
                fetch_next  = mem_addr + 32'd4;
                fetch_known = 1'b1;
            end
        end
        if (exe_valid && !be) begin
            retire_inst();
        end
    endtask

    task automatic step_cycle;
        @(posedge clk);
        #DRIVE_DELAY;
        check_hold();
        drive_memory();
        drive_backend();
        @(negedge clk);
        sample_edge();
    endtask

    task automatic finish_test(input string name, input int err_start);
        if (errors == err_start) begin
            $display("test %s: pass, %0d instructions retired", name, retired);
        end else begin
            $display("test %s: fail, %0d errors", name, errors - err_start);
            tests_failed++;
        end
    endtask

    initial begin
        int err_start;
        clk               = 1'b0;
        rst               = 1'b1;
        req_ready         = 1'b0;
        imem_rsp          = '0;
        branch_resolution = B_NT;
        alu_target        = '0;
        dc_stalled        = 1'b0;
        hazard            = '0;
        lfsr              = 32'd5500;
        stretch_mode      = 1'b0;
        ready_cnt         = 0;
        mem_busy          = 1'b0;
        mem_wait          = 0;
        mem_addr          = '0;
        fetch_next        = RESET_VEC;
        fetch_known       = 1'b1;
        exp_pc            = RESET_VEC;
        need_new          = 1'b1;
        cur_taken         = 1'b0;
        cur_target        = '0;
        stall_left        = 0;
        stall_kind        = 1'b0;
        held              = 1'b0;
        held_valid        = 1'b0;
        held_slot         = '0;
        first_req_seen    = 1'b0;
        retired           = 0;
        errors            = 0;
        tests_failed      = 0;
        fill_rom();

        err_start = errors;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (exe_valid !== 1'b0) begin
                report_value("exe_valid", exe_valid, 1'b0);
            end
            if (imem_req.valid !== 1'b0) begin
                report_value("imem_req.valid", imem_req.valid, 1'b0);
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        // first accepted request must go to the reset vector
        while (!first_req_seen) begin
            step_cycle();
        end
        finish_test("reset", err_start);

        err_start = errors;
        while (retired < N_MAIN) begin
            step_cycle();
        end
        finish_test("random_program", err_start);

        stretch_mode = 1'b1;
        ready_cnt    = 0;
        err_start    = errors;
        while (retired < N_MAIN + N_STRETCH) begin
            step_cycle();
        end
        finish_test("ready_stretches", err_start);

        $display("summary: 3 tests, %0d failed, %0d errors, %0d instructions retired",
                 tests_failed, errors, retired);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("ERROR: watchdog expired with %0d instructions retired", retired);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_fe.f ====
hdl/rv_fe_pkg.sv
hdl/rv_fe_pc_gen.sv
hdl/rv_fe_flow_decode.sv
hdl/rv_fe_stage_reg.sv
hdl/rv_fe_ctrl.sv
hdl/rv_fe_top.sv
testbench/rv_fe_tb.sv

// ==== Bender.yml ====
package:
  name: rv_fe

sources:
  - hdl/rv_fe_pkg.sv
  - hdl/rv_fe_pc_gen.sv
  - hdl/rv_fe_flow_decode.sv
  - hdl/rv_fe_stage_reg.sv
  - hdl/rv_fe_ctrl.sv
  - hdl/rv_fe_top.sv
  - target: test
    files:
      - testbench/rv_fe_tb.sv
